// ==== src/p2a_pkg.sv ====
// PCIe to Wishbone bridge types
`default_nettype none

package p2a_pkg;

  // bus widths on both sides of the bridge
  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;
  parameter int SEL_W  = DATA_W / 8;

  // count of low address bits that always pass through untranslated
  parameter int TRANS_LSB = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [SEL_W-1:0]  sel_t;

  // one downstream request whose addr carries the PCIe address at the input
  // and the system-bus address once the producer has translated it
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
    sel_t  sel;
  } p2a_req_t;

  // master-driven Wishbone classic signals
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat;
    sel_t  sel;
  } wb_mst_t;

endpackage

`default_nettype wire

// ==== src/p2a_addr_trans.sv ====
// BAR address translation
`default_nettype none

module p2a_addr_trans #(
  parameter int NUM_BARS = 7
) (
  input  wire p2a_pkg::addr_t                pcie_addr_i,
  input  wire [NUM_BARS-1:0]                 bar_hit_i,
  input  wire p2a_pkg::addr_t [NUM_BARS-1:0] bar_mask_i,
  input  wire p2a_pkg::addr_t [NUM_BARS-1:0] avl_base_i,
  output p2a_pkg::addr_t                     avl_addr_o
);

  // the low bits are never taken from the table entry
  localparam p2a_pkg::addr_t LSB_MASK = p2a_pkg::addr_t'((1 << p2a_pkg::TRANS_LSB) - 1);

  p2a_pkg::addr_t sel_mask;
  p2a_pkg::addr_t sel_base;
  p2a_pkg::addr_t trans_mask;

  // pick the mask and table entry of the BAR that was hit
  // any hit pattern that is not exactly one-hot leaves both at zero
  always_comb
  begin
    logic [NUM_BARS-1:0] pattern;
    sel_mask = '0;
    sel_base = '0;
    for (int i = 0; i < NUM_BARS; i++)
    begin
      pattern = '0;
      pattern[i] = 1'b1;
      if (bar_hit_i == pattern)
      begin
        sel_mask = bar_mask_i[i];
        sel_base = avl_base_i[i];
      end
    end
  end

  assign trans_mask = sel_mask & ~LSB_MASK;

  // upper bits come from the table where the mask is set, the rest
  // of the PCIe address is the offset inside the BAR window
  assign avl_addr_o = (pcie_addr_i & ~trans_mask) | (sel_base & trans_mask);

endmodule

`default_nettype wire

// ==== src/p2a_bar_decode.sv ====
// request producer with BAR decode
`default_nettype none

module p2a_bar_decode #(
  parameter int NUM_BARS = 7
) (
  input  wire                                clk_i,
  input  wire                                rst_n_i,
  input  wire                                req_valid_i,
  input  wire p2a_pkg::p2a_req_t             req_i,
  input  wire [NUM_BARS-1:0]                 bar_hit_i,
  input  wire p2a_pkg::addr_t [NUM_BARS-1:0] bar_mask_i,
  input  wire p2a_pkg::addr_t [NUM_BARS-1:0] avl_base_i,
  input  wire                                full_i,
  output logic                               req_ready_o,
  output logic                               push_o,
  output p2a_pkg::p2a_req_t                  push_data_o,
  output logic                               ur_o
);

  p2a_pkg::addr_t trans_addr;
  logic           accept;
  logic           hit_ok;
  logic           ur_q;

  p2a_addr_trans #(
    .NUM_BARS (NUM_BARS)
  ) p2a_addr_trans_i (
    .pcie_addr_i (req_i.addr),
    .bar_hit_i   (bar_hit_i),
    .bar_mask_i  (bar_mask_i),
    .avl_base_i  (avl_base_i),
    .avl_addr_o  (trans_addr)
  );

  // requests are taken only while the FIFO has room, even the ones
  // that will be dropped, so the source sees one simple rule
  assign req_ready_o = ~full_i;
  assign accept      = req_valid_i & req_ready_o;

  // exactly one bit set means nonzero with no second bit
  assign hit_ok = (bar_hit_i != '0) && ((bar_hit_i & (bar_hit_i - 1'b1)) == '0);

  assign push_o = accept & hit_ok;

  // the request goes on unchanged apart from its address
  always_comb
  begin
    push_data_o      = req_i;
    push_data_o.addr = trans_addr;
  end

  // a dropped request is reported one cycle after it was taken
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ur_q <= 1'b0;
    else
      ur_q <= accept & ~hit_ok;
  end

  assign ur_o = ur_q;

endmodule

`default_nettype wire

// ==== src/p2a_req_fifo.sv ====
// translated request FIFO
`default_nettype none

module p2a_req_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire                    clk_i,
  input  wire                    rst_n_i,
  input  wire                    push_i,
  input  wire p2a_pkg::p2a_req_t push_data_i,
  input  wire                    pop_i,
  output logic                   full_o,
  output logic                   empty_o,
  output p2a_pkg::p2a_req_t      head_o
);

  // depth is a power of two so the pointers wrap on their own
  localparam int PTR_W = $clog2(FIFO_DEPTH);

  p2a_pkg::p2a_req_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  // writes into a full buffer and reads from an empty one are ignored
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // the entry is written at the edge that pushes it
  always_ff @(posedge clk_i)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      // a push and a pop in the same cycle leave the count alone
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  assign full_o  = (count == (PTR_W+1)'(FIFO_DEPTH));
  assign empty_o = (count == '0);

  // the oldest entry is always presented to the consumer
  assign head_o = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== src/p2a_wb_master.sv ====
// Wishbone classic master
`default_nettype none

module p2a_wb_master (
  input  wire                    clk_i,
  input  wire                    rst_n_i,
  input  wire                    empty_i,
  input  wire p2a_pkg::p2a_req_t head_i,
  input  wire                    wb_ack_i,
  input  wire p2a_pkg::data_t    wb_dat_i,
  output logic                   pop_o,
  output p2a_pkg::wb_mst_t       wb_o,
  output logic                   rsp_valid_o,
  output p2a_pkg::data_t         rsp_data_o
);

  typedef enum logic {
    IDLE,
    BUS
  } wb_state_t;

  wb_state_t         state_q;
  logic              cyc_q;
  p2a_pkg::p2a_req_t req_q;
  logic              done;
  logic              rsp_valid_q;
  p2a_pkg::data_t    rsp_data_q;

  // the cycle ends at the edge that samples ack while the bus is ours
  assign done = (state_q == BUS) & wb_ack_i;

  // popping at that same edge means the next head is already there
  // when the FSM is back in IDLE
  assign pop_o = done;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= IDLE;
      cyc_q   <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          if (!empty_i)
          begin
            cyc_q   <= 1'b1;
            state_q <= BUS;
          end
        end
        BUS:
        begin
          // releasing here keeps cyc low for at least one cycle,
          // since IDLE needs an edge before it starts again
          if (wb_ack_i)
          begin
            cyc_q   <= 1'b0;
            state_q <= IDLE;
          end
        end
        default:
        begin
          cyc_q   <= 1'b0;
          state_q <= IDLE;
        end
      endcase
    end
  end

  // the request is captured when the cycle starts and held until ack
  always_ff @(posedge clk_i)
  begin
    if (state_q == IDLE && !empty_i)
      req_q <= head_i;
  end

  // read data goes back as a single pulse
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rsp_valid_q <= 1'b0;
    else
      rsp_valid_q <= done & ~req_q.we;
  end

  always_ff @(posedge clk_i)
  begin
    if (done && !req_q.we)
      rsp_data_q <= wb_dat_i;
  end

  // cyc and stb always move together in classic single cycles
  assign wb_o.cyc = cyc_q;
  assign wb_o.stb = cyc_q;
  assign wb_o.we  = req_q.we;
  assign wb_o.adr = req_q.addr;
  assign wb_o.dat = req_q.wdata;
  assign wb_o.sel = req_q.sel;

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_data_o  = rsp_data_q;

endmodule

`default_nettype wire

// ==== src/p2a_bridge_top.sv ====
// PCIe to Wishbone bridge top
`default_nettype none

module p2a_bridge_top #(
  parameter int NUM_BARS   = 7,
  parameter int FIFO_DEPTH = 4
) (
  input  wire                                clk_i,
  input  wire                                rst_n_i,
  input  wire                                req_valid_i,
  input  wire p2a_pkg::p2a_req_t             req_i,
  input  wire [NUM_BARS-1:0]                 bar_hit_i,
  input  wire p2a_pkg::addr_t [NUM_BARS-1:0] bar_mask_i,
  input  wire p2a_pkg::addr_t [NUM_BARS-1:0] avl_base_i,
  input  wire                                wb_ack_i,
  input  wire p2a_pkg::data_t                wb_dat_i,
  output logic                               req_ready_o,
  output logic                               ur_o,
  output p2a_pkg::wb_mst_t                   wb_o,
  output logic                               rsp_valid_o,
  output p2a_pkg::data_t                     rsp_data_o
);

  // producer to FIFO
  logic              push;
  p2a_pkg::p2a_req_t push_data;
  logic              full;

  // FIFO to consumer
  logic              empty;
  p2a_pkg::p2a_req_t head;
  logic              pop;

  p2a_bar_decode #(
    .NUM_BARS (NUM_BARS)
  ) p2a_bar_decode_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .bar_hit_i   (bar_hit_i),
    .bar_mask_i  (bar_mask_i),
    .avl_base_i  (avl_base_i),
    .full_i      (full),
    .req_ready_o (req_ready_o),
    .push_o      (push),
    .push_data_o (push_data),
    .ur_o        (ur_o)
  );

  p2a_req_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) p2a_req_fifo_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .full_o      (full),
    .empty_o     (empty),
    .head_o      (head)
  );

  p2a_wb_master p2a_wb_master_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .empty_i     (empty),
    .head_i      (head),
    .wb_ack_i    (wb_ack_i),
    .wb_dat_i    (wb_dat_i),
    .pop_o       (pop),
    .wb_o        (wb_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o)
  );

endmodule

`default_nettype wire

// ==== verif/p2a_bridge_tb.sv ====
// PCIe to Wishbone bridge testbench
`default_nettype none

module p2a_bridge_tb;

  localparam int NUM_BARS   = 7;
  localparam int FIFO_DEPTH = 4;
  localparam int NUM_ROWS   = 12;
  localparam int TIMEOUT    = 500;

  // BAR masks of different sizes and their table entries, from the ROM entry down to BAR 0
  localparam p2a_pkg::addr_t [NUM_BARS-1:0] BAR_MASK = {32'hFFFF_FFFF, 32'hF000_0000,
    32'hFFFF_FF00, 32'hFF00_0000, 32'hFFF0_0000, 32'hFFFF_0000, 32'hFFFF_F000};
  localparam p2a_pkg::addr_t [NUM_BARS-1:0] AVL_BASE = {32'h7FEE_DDCC, 32'h6123_4567,
    32'h5E5E_5E5F, 32'h4C00_1234, 32'h3A5B_C0DE, 32'h2468_ACEF, 32'h1357_9FFF};

  // one stimulus row where ur marks a request that must be dropped
  typedef struct packed {
    logic                we;
    p2a_pkg::addr_t      addr;
    logic [NUM_BARS-1:0] hit;
    p2a_pkg::data_t      wdata;
    p2a_pkg::sel_t       sel;
    logic                ur;
  } row_t;

  logic                clk_i       = 1'b0;
  logic                rst_n_i     = 1'b0;
  logic                req_valid_i = 1'b0;
  p2a_pkg::p2a_req_t   req_i       = '0;
  logic [NUM_BARS-1:0] bar_hit_i   = '0;
  logic                wb_ack_i    = 1'b0;
  p2a_pkg::data_t      wb_dat_i    = '0;
  logic                req_ready_o;
  logic                ur_o;
  p2a_pkg::wb_mst_t    wb_o;
  logic                rsp_valid_o;
  p2a_pkg::data_t      rsp_data_o;

  row_t             rows [NUM_ROWS];
  p2a_pkg::wb_mst_t exp_q [$];
  p2a_pkg::wb_mst_t cur      = '0;
  logic             checking = 1'b0;
  logic             row_ur   = 1'b0;
  logic             stall    = 1'b0;
  logic             in_cycle = 1'b0;
  logic             ack_seen = 1'b0;
  logic             ur_due   = 1'b0;
  logic             rsp_due  = 1'b0;
  logic             answer   = 1'b0;
  p2a_pkg::data_t   answer_dat = '0;
  int               delay    = 2;
  int               seed     = 32'h78bee56c;

  p2a_bridge_top p2a_bridge_top_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .bar_hit_i   (bar_hit_i),
    .bar_mask_i  (BAR_MASK),
    .avl_base_i  (AVL_BASE),
    .wb_ack_i    (wb_ack_i),
    .wb_dat_i    (wb_dat_i),
    .req_ready_o (req_ready_o),
    .ur_o        (ur_o),
    .wb_o        (wb_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o)
  );

  always #2 clk_i = ~clk_i;

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic mismatch_error(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    stop_run();
  endtask

  task automatic message_error(input string msg);
    $display("error at time %0t: %s", $time, msg);
    stop_run();
  endtask

  // a single hit selects that BAR and each address bit above the low TRANS_LSB
  // bits is taken from the table entry where the BAR mask has a one
  function automatic p2a_pkg::addr_t expected_addr(input row_t r);
    p2a_pkg::addr_t mask;
    p2a_pkg::addr_t base;
    p2a_pkg::addr_t result;
    mask   = '0;
    base   = '0;
    result = r.addr;
    if ($countones(r.hit) == 1)
    begin
      for (int i = 0; i < NUM_BARS; i++)
      begin
        if (r.hit[i])
        begin
          mask = BAR_MASK[i];
          base = AVL_BASE[i];
        end
      end
    end
    for (int b = p2a_pkg::TRANS_LSB; b < p2a_pkg::ADDR_W; b++)
    begin
      if (mask[b])
        result[b] = base[b];
    end
    return result;
  endfunction

  // present one row and hold it until the bridge takes it
  task automatic send_row(input row_t r);
    int waited;
    waited = 0;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_i       <= p2a_pkg::p2a_req_t'{we: r.we, addr: r.addr, wdata: r.wdata, sel: r.sel};
    bar_hit_i   <= r.hit;
    row_ur      <= r.ur;
    if (!r.ur)
      exp_q.push_back(p2a_pkg::wb_mst_t'{cyc: 1'b1, stb: 1'b1, we: r.we,
        adr: expected_addr(r), dat: r.wdata, sel: r.sel});
    @(negedge clk_i);
    while (!req_ready_o)
    begin
      waited++;
      assert (waited < TIMEOUT)
        else message_error("timeout waiting for req_ready_o to accept a request");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || in_cycle)
    begin
      @(posedge clk_i);
      waited++;
      assert (waited < TIMEOUT)
        else message_error("timeout waiting for the pending bus cycles to finish");
    end
  endtask

  task automatic compare_bus();
    assert (wb_o.stb == cur.stb) else mismatch_error("wb_o.stb", 32'(wb_o.stb), 32'(cur.stb));
    assert (wb_o.we == cur.we) else mismatch_error("wb_o.we", 32'(wb_o.we), 32'(cur.we));
    assert (wb_o.adr == cur.adr) else mismatch_error("wb_o.adr", wb_o.adr, cur.adr);
    assert (wb_o.dat == cur.dat) else mismatch_error("wb_o.dat", wb_o.dat, cur.dat);
    assert (wb_o.sel == cur.sel) else mismatch_error("wb_o.sel", 32'(wb_o.sel), 32'(cur.sel));
  endtask

  // Wishbone slave model decides mid-cycle and drives ack on the next rising edge
  always @(negedge clk_i)
  begin
    answer     = 1'b0;
    answer_dat = ~wb_o.adr;
    if (wb_o.cyc && wb_o.stb && !wb_ack_i && !stall)
    begin
      if (delay == 0)
      begin
        answer = 1'b1;
        delay  = $unsigned($random(seed)) % 6;
      end
      else
        delay = delay - 1;
    end
  end

  always @(posedge clk_i)
  begin
    wb_ack_i <= answer;
    wb_dat_i <= answer_dat;
  end

  // the monitor runs mid-cycle and each due flag holds what the next cycle must show
  always @(negedge clk_i)
  begin
    if (checking)
    begin
      assert (ur_o == ur_due) else mismatch_error("ur_o", 32'(ur_o), 32'(ur_due));
      assert (rsp_valid_o == rsp_due)
        else mismatch_error("rsp_valid_o", 32'(rsp_valid_o), 32'(rsp_due));
      if (rsp_valid_o)
      begin
        assert (rsp_data_o == ~cur.adr)
          else mismatch_error("rsp_data_o", rsp_data_o, ~cur.adr);
      end
      if (ack_seen)
      begin
        assert (!wb_o.cyc) else message_error("cyc stayed high after the edge that sampled ack");
      end
      if (wb_o.cyc && !in_cycle)
      begin
        assert (exp_q.size() != 0)
          else message_error("a bus cycle started with no valid request pending");
        cur      = exp_q.pop_front();
        in_cycle = 1'b1;
      end
      // from its start until ack the cycle keeps cyc high and every signal unchanged
      if (in_cycle)
      begin
        assert (wb_o.cyc) else message_error("cyc fell before the slave raised ack");
        compare_bus();
      end
      else
      begin
        assert (!wb_o.stb) else mismatch_error("wb_o.stb", 32'(wb_o.stb), 32'd0);
      end
      ur_due   = req_valid_i && req_ready_o && row_ur;
      ack_seen = in_cycle && wb_ack_i;
      rsp_due  = ack_seen && !cur.we;
      if (ack_seen)
        in_cycle = 1'b0;
    end
  end

  initial
  begin
    // every BAR including the ROM is hit, then a zero hit and a double hit sit between valid ones
    rows[0]  = '{1'b1, 32'hABCD_1234, 7'b0000001, 32'h1111_0001, 4'hF, 1'b0};
    rows[1]  = '{1'b0, 32'hABCD_5678, 7'b0000010, 32'h0000_0000, 4'hF, 1'b0};
    rows[2]  = '{1'b1, 32'h1234_5678, 7'b0000100, 32'h2222_0002, 4'h3, 1'b0};
    rows[3]  = '{1'b0, 32'h9876_5432, 7'b0001000, 32'h0000_0000, 4'hF, 1'b0};
    rows[4]  = '{1'b1, 32'hCAFE_BA5E, 7'b0010000, 32'h3333_0003, 4'hC, 1'b0};
    rows[5]  = '{1'b0, 32'h5555_AAAA, 7'b0100000, 32'h0000_0000, 4'hF, 1'b0};
    rows[6]  = '{1'b0, 32'hFFFF_FFF7, 7'b1000000, 32'h0000_0000, 4'hF, 1'b0};
    rows[7]  = '{1'b1, 32'h0BAD_0000, 7'b0000000, 32'hDEAD_0007, 4'hF, 1'b1};
    rows[8]  = '{1'b0, 32'h0000_0ABC, 7'b0000001, 32'h0000_0000, 4'hF, 1'b0};
    rows[9]  = '{1'b1, 32'h0BAD_0004, 7'b0010010, 32'hDEAD_0009, 4'hF, 1'b1};
    rows[10] = '{1'b1, 32'h7654_3210, 7'b0000010, 32'h4444_0004, 4'h1, 1'b0};
    rows[11] = '{1'b0, 32'h0F0F_0F0F, 7'b0000100, 32'h0000_0000, 4'hF, 1'b0};

    repeat (16) @(posedge clk_i);
    rst_n_i  <= 1'b1;
    checking <= 1'b1;
    @(negedge clk_i);
    assert (req_ready_o) else mismatch_error("req_ready_o", 32'(req_ready_o), 32'd1);
    assert (!wb_o.cyc) else mismatch_error("wb_o.cyc", 32'(wb_o.cyc), 32'd0);
    assert (!wb_o.stb) else mismatch_error("wb_o.stb", 32'(wb_o.stb), 32'd0);
    assert (!ur_o) else mismatch_error("ur_o", 32'(ur_o), 32'd0);
    assert (!rsp_valid_o) else mismatch_error("rsp_valid_o", 32'(rsp_valid_o), 32'd0);

    for (int i = 0; i < NUM_ROWS; i++)
      send_row(rows[i]);
    wait_drained();

    // with the slave stalled the FIFO fills and ready drops after FIFO_DEPTH requests
    @(posedge clk_i);
    stall <= 1'b1;
    for (int i = 0; i < FIFO_DEPTH; i++)
    begin
      send_row(rows[i]);
      @(negedge clk_i);
      assert (req_ready_o == (i < FIFO_DEPTH - 1))
        else mismatch_error("req_ready_o", 32'(req_ready_o), 32'(i < FIFO_DEPTH - 1));
    end
    repeat (10)
    begin
      @(negedge clk_i);
      assert (!req_ready_o) else mismatch_error("req_ready_o", 32'(req_ready_o), 32'd0);
    end
    @(posedge clk_i);
    stall <= 1'b0;
    send_row(rows[FIFO_DEPTH]);
    wait_drained();
    repeat (3) @(negedge clk_i);

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
src/p2a_pkg.sv
src/p2a_addr_trans.sv
src/p2a_bar_decode.sv
src/p2a_req_fifo.sv
src/p2a_wb_master.sv
src/p2a_bridge_top.sv
verif/p2a_bridge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the bridge testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module p2a_bridge_tb \
  -f src.f -o p2a_sim \
  && ./obj_dir/p2a_sim | tee /dev/stderr | grep -qx "PASS: all tests" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
